//--- verilog/consoleBus_pkg.sv
/*
 * Console bus definitions
 * Bus widths, the CPU address map, chip register offsets and the
 * fill value for reads that hit nothing
 */
package consoleBus_pkg;

    typedef logic [15:0] addr_t;     // CPU bus address
    typedef logic [7:0]  data_t;     // Bus data byte
    typedef logic [13:0] ramAddr_t;  // 16 KB work RAM
    typedef logic [13:0] cartAddr_t; // Address inside one cartridge window

    // CPU address map
    localparam addr_t RAM_TOP        = 16'h3FFF;
    localparam addr_t CART_LOW_BASE  = 16'h4000;
    localparam addr_t CART_HIGH_BASE = 16'h8000; // Runs up to the GTIA window
    localparam addr_t GTIA_BASE      = 16'hC000; // 256 byte window
    localparam addr_t ANTIC_BASE     = 16'hD400; // 256 byte window

    // GTIA colour registers
    localparam logic [7:0] COLPF0_OFS = 8'h16;
    localparam logic [7:0] COLPF1_OFS = 8'h17;
    localparam logic [7:0] COLPF2_OFS = 8'h18;
    localparam logic [7:0] COLBK_OFS  = 8'h1A;

    // ANTIC screen base pointer, low byte then high byte
    localparam logic [7:0] SCRBASEL_OFS = 8'h02;
    localparam logic [7:0] SCRBASEH_OFS = 8'h03;

    // Open bus value
    localparam data_t UNMAPPED_DATA = 8'hFF;

    // Strobe to read data for registers, cartridge and open bus
    localparam int REG_READ_LATENCY = 2;

endpackage

//--- verilog/workRam.sv
/*
 * Work RAM
 * 16 KB single-port synchronous RAM, read data one cycle after the enable
 */
`timescale 1ns/10ps

module workRam (
    input  logic                     USER_CLK,
    input  logic                     ramEn,
    input  logic                     ramWrite,
    input  consoleBus_pkg::ramAddr_t ramAddr,
    input  consoleBus_pkg::data_t    ramWdata,
    output consoleBus_pkg::data_t    ramRdata
);
    import consoleBus_pkg::*;

    localparam int RAM_DEPTH = 1 << $bits(ramAddr_t);

    data_t mem [RAM_DEPTH];

    always_ff @(posedge USER_CLK) begin
        if (ramEn) begin
            if (ramWrite) begin
                mem[ramAddr] <= ramWdata;
            end
            ramRdata <= mem[ramAddr]; // Old data on a write
        end
    end

endmodule

//--- verilog/busArbiter.sv
/*
 * Work RAM arbiter
 * Playfield DMA has fixed priority, a CPU request waits in a one-entry
 * hold until a cycle without DMA. Each RAM cycle is tagged with its owner
 * so the read data goes back to the right peer
 */
`timescale 1ns/10ps

module busArbiter (
    input  logic                     USER_CLK,
    input  logic                     nRES_L,
    input  logic                     cpuRamReq,
    input  logic                     cpuRamWrite,
    input  consoleBus_pkg::ramAddr_t cpuRamAddr,
    input  consoleBus_pkg::data_t    cpuRamWdata,
    output consoleBus_pkg::data_t    cpuRamRdata,
    output logic                     cpuRamRdValid,
    output logic                     cpuRamDone,
    input  logic                     dmaReq,
    input  consoleBus_pkg::ramAddr_t dmaAddr,
    output logic                     dmaGrant,
    output consoleBus_pkg::data_t    dmaRdata,
    output logic                     dmaRdValid,
    output logic                     ramEn,
    output logic                     ramWrite,
    output consoleBus_pkg::ramAddr_t ramAddr,
    output consoleBus_pkg::data_t    ramWdata,
    input  consoleBus_pkg::data_t    ramRdata
);
    import consoleBus_pkg::*;

    logic     holdValid, holdWrite;
    ramAddr_t holdAddr;
    data_t    holdWdata;
    logic     cpuServe;
    logic     cpuTag, cpuTagRead, dmaTag; // Owner of last cycle's RAM access

    // CPU only gets the RAM when DMA is quiet, like RDY halting the 6502
    assign cpuServe = holdValid && !dmaReq;
    assign dmaGrant = dmaReq;

    assign ramEn    = dmaReq || holdValid;
    assign ramWrite = cpuServe && holdWrite;
    assign ramAddr  = dmaReq ? dmaAddr : holdAddr;
    assign ramWdata = holdWdata;

    // RAM read data fans out to both peers, the tags qualify it
    assign dmaRdata      = ramRdata;
    assign dmaRdValid    = dmaTag;
    assign cpuRamRdata   = ramRdata;
    assign cpuRamRdValid = cpuTagRead;
    assign cpuRamDone    = cpuTag; // Writes and reads alike

    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            holdValid  <= 1'b0;
            cpuTag     <= 1'b0;
            cpuTagRead <= 1'b0;
            dmaTag     <= 1'b0;
        end else begin
            if (cpuServe) begin
                holdValid <= 1'b0;
            end
            if (cpuRamReq) begin
                holdValid <= 1'b1; // memoryMap never has two in flight
            end
            cpuTag     <= cpuServe;
            cpuTagRead <= cpuServe && !holdWrite;
            dmaTag     <= dmaReq;
        end
    end

    always_ff @(posedge USER_CLK) begin
        if (cpuRamReq) begin
            holdWrite <= cpuRamWrite;
            holdAddr  <= cpuRamAddr;
            holdWdata <= cpuRamWdata;
        end
    end

endmodule

//--- verilog/memoryMap.sv
/*
 * CPU memory map
 * Registers each CPU strobe, decodes it into RAM, cartridge, chip register
 * or open bus, holds the colour and screen base registers and returns
 * read data with a fixed latency for everything that is not RAM
 */
`timescale 1ns/10ps

module memoryMap (
    input  logic                      USER_CLK,
    input  logic                      nRES_L,
    input  logic                      cpuStrobe,
    input  logic                      cpuWrite,
    input  consoleBus_pkg::addr_t     cpuAddr,
    input  consoleBus_pkg::data_t     cpuWdata,
    output consoleBus_pkg::data_t     cpuRdata,
    output logic                      cpuRdValid,
    output logic                      cpuBusy,
    output logic                      cartSelLow,
    output logic                      cartSelHigh,
    output consoleBus_pkg::cartAddr_t cartAddr,
    input  consoleBus_pkg::data_t     cartData,
    output logic                      cpuRamReq,
    output logic                      cpuRamWrite,
    output consoleBus_pkg::ramAddr_t  cpuRamAddr,
    output consoleBus_pkg::data_t     cpuRamWdata,
    input  consoleBus_pkg::data_t     cpuRamRdata,
    input  logic                      cpuRamRdValid,
    input  logic                      cpuRamDone,
    output consoleBus_pkg::data_t     colbk,
    output consoleBus_pkg::data_t     colpf0,
    output consoleBus_pkg::data_t     colpf1,
    output consoleBus_pkg::data_t     colpf2,
    output consoleBus_pkg::addr_t     scrBase
);
    import consoleBus_pkg::*;

    localparam int RET_STAGES = REG_READ_LATENCY - 1; // Request stage is the first

    logic                  reqValid, reqWrite;
    addr_t                 reqAddr;
    data_t                 reqWdata;
    logic                  isRam, isCartLow, isCartHigh, isGtia, isAntic;
    logic [7:0]            regOfs;
    data_t                 regValue, rdMux;
    logic [RET_STAGES-1:0] retValid;
    data_t                 retData [RET_STAGES];
    logic                  accessDone;

    // Decode of the registered request
    assign isRam      = (reqAddr <= RAM_TOP);
    assign isCartLow  = (reqAddr >= CART_LOW_BASE) && (reqAddr < CART_HIGH_BASE);
    assign isCartHigh = (reqAddr >= CART_HIGH_BASE) && (reqAddr < GTIA_BASE);
    assign isGtia     = (reqAddr[15:8] == GTIA_BASE[15:8]);
    assign isAntic    = (reqAddr[15:8] == ANTIC_BASE[15:8]);
    assign regOfs     = reqAddr[7:0];

    always_comb begin
        regValue = UNMAPPED_DATA; // Unused offsets read as open bus
        if (isGtia) begin
            case (regOfs)
                COLBK_OFS:  regValue = colbk;
                COLPF0_OFS: regValue = colpf0;
                COLPF1_OFS: regValue = colpf1;
                COLPF2_OFS: regValue = colpf2;
                default:    regValue = UNMAPPED_DATA;
            endcase
        end else if (isAntic) begin
            case (regOfs)
                SCRBASEL_OFS: regValue = scrBase[7:0];
                SCRBASEH_OFS: regValue = scrBase[15:8];
                default:      regValue = UNMAPPED_DATA;
            endcase
        end
    end

    assign rdMux = (isCartLow || isCartHigh) ? cartData : regValue;

    // Cartridge chip selects live for the request cycle only
    assign cartSelLow  = !(reqValid && isCartLow);
    assign cartSelHigh = !(reqValid && isCartHigh);
    assign cartAddr    = reqAddr[13:0];

    assign cpuRamReq   = reqValid && isRam;
    assign cpuRamWrite = reqWrite;
    assign cpuRamAddr  = reqAddr[13:0];
    assign cpuRamWdata = reqWdata;

    // RAM data arrives on its own schedule and never meets the fixed path
    assign cpuRdValid = retValid[RET_STAGES-1] || cpuRamRdValid;
    assign cpuRdata   = cpuRamRdValid ? cpuRamRdata : retData[RET_STAGES-1];

    assign accessDone = retValid[RET_STAGES-1] || cpuRamDone
                        || (reqValid && reqWrite && !isRam);

    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            reqValid <= 1'b0;
            retValid <= '0;
            cpuBusy  <= 1'b0;
        end else begin
            reqValid    <= cpuStrobe;
            retValid[0] <= reqValid && !reqWrite && !isRam;
            for (int i = 1; i < RET_STAGES; i++) begin
                retValid[i] <= retValid[i-1];
            end
            if (cpuStrobe) begin
                cpuBusy <= 1'b1;
            end else if (accessDone) begin
                cpuBusy <= 1'b0;
            end
        end
    end

    always_ff @(posedge USER_CLK) begin
        if (cpuStrobe) begin
            reqWrite <= cpuWrite;
            reqAddr  <= cpuAddr;
            reqWdata <= cpuWdata;
        end
        retData[0] <= rdMux; // cartData sampled here
        for (int i = 1; i < RET_STAGES; i++) begin
            retData[i] <= retData[i-1];
        end
    end

    // Chip registers
    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            colbk   <= '0;
            colpf0  <= '0;
            colpf1  <= '0;
            colpf2  <= '0;
            scrBase <= '0;
        end else if (reqValid && reqWrite) begin
            if (isGtia) begin
                case (regOfs)
                    COLBK_OFS:  colbk  <= reqWdata;
                    COLPF0_OFS: colpf0 <= reqWdata;
                    COLPF1_OFS: colpf1 <= reqWdata;
                    COLPF2_OFS: colpf2 <= reqWdata;
                    default: ;
                endcase
            end
            if (isAntic) begin
                case (regOfs)
                    SCRBASEL_OFS: scrBase[7:0]  <= reqWdata;
                    SCRBASEH_OFS: scrBase[15:8] <= reqWdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- verilog/playfieldFetch.sv
/*
 * Playfield fetcher
 * On each line start, DMA-reads one line of screen bytes from work RAM
 * and maps each byte through the colour registers to one pixel
 */
`timescale 1ns/10ps

module playfieldFetch #(
    parameter int LINE_BYTES  = 40,
    parameter int FRAME_LINES = 192
) (
    input  logic                     USER_CLK,
    input  logic                     nRES_L,
    input  logic                     frameStart,
    input  logic                     lineStart,
    input  consoleBus_pkg::addr_t    scrBase,
    input  consoleBus_pkg::data_t    colbk,
    input  consoleBus_pkg::data_t    colpf0,
    input  consoleBus_pkg::data_t    colpf1,
    input  consoleBus_pkg::data_t    colpf2,
    output logic                     dmaReq,
    output consoleBus_pkg::ramAddr_t dmaAddr,
    input  logic                     dmaGrant,
    input  consoleBus_pkg::data_t    dmaRdata,
    input  logic                     dmaRdValid,
    output logic                     pixValid,
    output consoleBus_pkg::data_t    pixColor
);
    import consoleBus_pkg::*;

    localparam int LINE_W = (FRAME_LINES > 1) ? $clog2(FRAME_LINES) : 1;
    localparam int CNT_W  = $clog2(LINE_BYTES + 1);

    logic [LINE_W-1:0] lineNum, startLine;
    logic [CNT_W-1:0]  issueLeft; // Bytes still to request
    logic [CNT_W-1:0]  recvLeft;  // Bytes still to come back
    logic              lineBusy, lineDone;
    addr_t             lineBase;
    data_t             pickColor;

    // A frame start in the same cycle already counts as line 0
    assign startLine = frameStart ? '0 : lineNum;
    assign lineBase  = scrBase + addr_t'(startLine) * addr_t'(LINE_BYTES);
    assign dmaReq    = (issueLeft != '0);

    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            lineNum   <= '0;
            issueLeft <= '0;
            recvLeft  <= '0;
            lineBusy  <= 1'b0;
            lineDone  <= 1'b0;
            dmaAddr   <= '0;
            pixValid  <= 1'b0;
        end else begin
            pixValid <= dmaRdValid;
            lineDone <= dmaRdValid && (recvLeft == CNT_W'(1)); // Lines up with last pixel
            if (lineStart && !lineBusy) begin
                lineBusy  <= 1'b1;
                issueLeft <= CNT_W'(LINE_BYTES);
                recvLeft  <= CNT_W'(LINE_BYTES);
                dmaAddr   <= ramAddr_t'(lineBase); // Wraps inside the RAM
            end else begin
                if (dmaGrant) begin
                    issueLeft <= issueLeft - 1'b1;
                    dmaAddr   <= dmaAddr + 1'b1;
                end
                if (dmaRdValid) begin
                    recvLeft <= recvLeft - 1'b1;
                end
                if (lineDone) begin
                    lineBusy <= 1'b0;
                end
            end
            if (frameStart) begin
                lineNum <= '0;
            end else if (lineDone) begin
                lineNum <= (lineNum == LINE_W'(FRAME_LINES - 1)) ? '0 : lineNum + 1'b1;
            end
        end
    end

    // Two low bits pick background or one of three playfield colours
    always_comb begin
        case (dmaRdata[1:0])
            2'd0:    pickColor = colbk;
            2'd1:    pickColor = colpf0;
            2'd2:    pickColor = colpf1;
            default: pickColor = colpf2;
        endcase
    end

    always_ff @(posedge USER_CLK) begin
        if (dmaRdValid) begin
            pixColor <= pickColor;
        end
    end

endmodule

//--- verilog/consoleTop.sv
/*
 * Console bus top level
 * CPU port through the memory map, work RAM shared with playfield DMA
 */
`timescale 1ns/10ps

module consoleTop #(
    parameter int LINE_BYTES  = 40,
    parameter int FRAME_LINES = 192
) (
    input  logic                      USER_CLK,
    input  logic                      nRES_L,
    input  logic                      cpuStrobe,
    input  logic                      cpuWrite,
    input  consoleBus_pkg::addr_t     cpuAddr,
    input  consoleBus_pkg::data_t     cpuWdata,
    output consoleBus_pkg::data_t     cpuRdata,
    output logic                      cpuRdValid,
    output logic                      cpuBusy,
    output logic                      cartSelLow,
    output logic                      cartSelHigh,
    output consoleBus_pkg::cartAddr_t cartAddr,
    input  consoleBus_pkg::data_t     cartData,
    input  logic                      frameStart,
    input  logic                      lineStart,
    output logic                      pixValid,
    output consoleBus_pkg::data_t     pixColor
);
    import consoleBus_pkg::*;

    // CPU side RAM path
    logic     cpuRamReq, cpuRamWrite, cpuRamRdValid, cpuRamDone;
    ramAddr_t cpuRamAddr;
    data_t    cpuRamWdata, cpuRamRdata;

    // Playfield DMA path
    logic     dmaReq, dmaGrant, dmaRdValid;
    ramAddr_t dmaAddr;
    data_t    dmaRdata;

    logic     ramEn, ramWrite;
    ramAddr_t ramAddr;
    data_t    ramWdata, ramRdata;

    data_t    colbk, colpf0, colpf1, colpf2;
    addr_t    scrBase;

    memoryMap memMap (
        .USER_CLK, .nRES_L, .cpuStrobe, .cpuWrite, .cpuAddr, .cpuWdata,
        .cpuRdata, .cpuRdValid, .cpuBusy,
        .cartSelLow, .cartSelHigh, .cartAddr, .cartData,
        .cpuRamReq, .cpuRamWrite, .cpuRamAddr, .cpuRamWdata,
        .cpuRamRdata, .cpuRamRdValid, .cpuRamDone,
        .colbk, .colpf0, .colpf1, .colpf2, .scrBase
    );

    busArbiter arb (
        .USER_CLK, .nRES_L,
        .cpuRamReq, .cpuRamWrite, .cpuRamAddr, .cpuRamWdata,
        .cpuRamRdata, .cpuRamRdValid, .cpuRamDone,
        .dmaReq, .dmaAddr, .dmaGrant, .dmaRdata, .dmaRdValid,
        .ramEn, .ramWrite, .ramAddr, .ramWdata, .ramRdata
    );

    workRam ram (.USER_CLK, .ramEn, .ramWrite, .ramAddr, .ramWdata, .ramRdata);

    playfieldFetch #(
        .LINE_BYTES  (LINE_BYTES),
        .FRAME_LINES (FRAME_LINES)
    ) fetch (
        .USER_CLK, .nRES_L, .frameStart, .lineStart, .scrBase,
        .colbk, .colpf0, .colpf1, .colpf2,
        .dmaReq, .dmaAddr, .dmaGrant, .dmaRdata, .dmaRdValid,
        .pixValid, .pixColor
    );

endmodule

//--- tb/consoleTop_asserts.sv
/*
 * Console bus protocol checks
 * Bound into consoleTop, watches the CPU handshake and the cartridge selects
 */
`timescale 1ns/10ps

module consoleTop_asserts (
    input logic USER_CLK,
    input logic nRES_L,
    input logic cpuStrobe,
    input logic cpuBusy,
    input logic cpuRdValid,
    input logic cartSelLow,
    input logic cartSelHigh
);

    int assertFails = 0; // Failed assertion count

    // Driver has to wait for the previous access
    strobeWhenIdle: assert property (@(posedge USER_CLK) disable iff (nRES_L)
        cpuStrobe |-> !cpuBusy)
        else begin
            assertFails++;
            $error("CPU strobe while the bus is busy");
        end

    cartSelOneHot: assert property (@(posedge USER_CLK) disable iff (nRES_L)
        !(!cartSelLow && !cartSelHigh))
        else begin
            assertFails++;
            $error("both cartridge selects low");
        end

    // Read data only inside an access
    validOnlyBusy: assert property (@(posedge USER_CLK) disable iff (nRES_L)
        cpuRdValid |-> cpuBusy)
        else begin
            assertFails++;
            $error("read valid while the CPU port is idle");
        end

endmodule

bind consoleTop consoleTop_asserts protoCheck (
    .USER_CLK, .nRES_L, .cpuStrobe, .cpuBusy, .cpuRdValid, .cartSelLow, .cartSelHigh
);

//--- tb/consoleTop_tb.sv
/*
 * Console bus testbench
 * RAM, register, cartridge and playfield traffic against a reference model
 */
`timescale 1ns/10ps

module consoleTop_tb;
    import consoleBus_pkg::*;

    localparam int LINE_BYTES   = 8;
    localparam int FRAME_LINES  = 4;
    localparam int RAM_TESTS    = 24;
    localparam int SCREEN_BYTES = LINE_BYTES * FRAME_LINES;
    localparam int CPU_OPS      = 2 * RAM_TESTS + SCREEN_BYTES + 30;
    localparam int CYCLE_LIMIT  = 2 * (6 * CPU_OPS + 8 * (3 * LINE_BYTES + 10)) + 50;
    localparam addr_t REG_ADDRS [9] = '{16'hC01A, 16'hC016, 16'hC017, 16'hC018,
        16'hD402, 16'hD403, 16'hC000, 16'hD4FF, 16'hE123};

    logic  USER_CLK = 1'b0;
    logic  nRES_L, cpuStrobe, cpuWrite, cpuRdValid, cpuBusy;
    logic  cartSelLow, cartSelHigh, frameStart, lineStart, pixValid;
    addr_t cpuAddr;
    data_t cpuWdata, cpuRdata, cartData, pixColor;
    cartAddr_t cartAddr;

    // Reference model state
    data_t ramModel [16384];
    data_t modelColbk, modelColpf0, modelColpf1, modelColpf2;
    addr_t modelScrBase;
    int    lineNo;
    data_t expRead [$];
    logic  expFixed [$];
    int    expCycle [$];
    data_t expPix [$];
    addr_t ramAddrs [RAM_TESTS];
    int    cycleCount = 0;
    int    strobeCycle;
    int    errors = 0;
    int    checks = 0;

    consoleTop #(.LINE_BYTES(LINE_BYTES), .FRAME_LINES(FRAME_LINES)) uut (
        .USER_CLK, .nRES_L, .cpuStrobe, .cpuWrite, .cpuAddr, .cpuWdata,
        .cpuRdata, .cpuRdValid, .cpuBusy, .cartSelLow, .cartSelHigh, .cartAddr,
        .cartData, .frameStart, .lineStart, .pixValid, .pixColor
    );

    always #5 USER_CLK = ~USER_CLK;

    function automatic data_t colourOf(input data_t b);
        case (b[1:0])
            2'd0:    return modelColbk;
            2'd1:    return modelColpf0;
            2'd2:    return modelColpf1;
            default: return modelColpf2;
        endcase
    endfunction

    // Expected read data for RAM, chip registers and open bus
    function automatic data_t expectedRead(input addr_t a);
        if (a <= RAM_TOP) return ramModel[a[13:0]];
        if (a[15:8] == GTIA_BASE[15:8]) begin
            case (a[7:0])
                COLBK_OFS:  return modelColbk;
                COLPF0_OFS: return modelColpf0;
                COLPF1_OFS: return modelColpf1;
                COLPF2_OFS: return modelColpf2;
                default:    return UNMAPPED_DATA;
            endcase
        end
        if (a[15:8] == ANTIC_BASE[15:8]) begin
            if (a[7:0] == SCRBASEL_OFS) return modelScrBase[7:0];
            if (a[7:0] == SCRBASEH_OFS) return modelScrBase[15:8];
        end
        return UNMAPPED_DATA;
    endfunction

    task automatic nextCycle();
        @(posedge USER_CLK);
        #1;
    endtask

    task automatic strobeBus(input logic wr, input addr_t a, input data_t d);
        while (cpuBusy) nextCycle();
        cpuStrobe   = 1'b1;
        cpuWrite    = wr;
        cpuAddr     = a;
        cpuWdata    = d;
        strobeCycle = cycleCount;
        nextCycle();
        cpuStrobe = 1'b0;
    endtask

    task automatic writeByte(input addr_t a, input data_t d);
        strobeBus(1'b1, a, d);
        if (a <= RAM_TOP) ramModel[a[13:0]] = d;
        else if (a == GTIA_BASE + COLBK_OFS) modelColbk = d;
        else if (a == GTIA_BASE + COLPF0_OFS) modelColpf0 = d;
        else if (a == GTIA_BASE + COLPF1_OFS) modelColpf1 = d;
        else if (a == GTIA_BASE + COLPF2_OFS) modelColpf2 = d;
        else if (a == ANTIC_BASE + SCRBASEL_OFS) modelScrBase[7:0] = d;
        else if (a == ANTIC_BASE + SCRBASEH_OFS) modelScrBase[15:8] = d;
    endtask

    task automatic readByte(input addr_t a, input logic fixedLat);
        data_t exp;
        exp = expectedRead(a);
        strobeBus(1'b0, a, '0);
        expRead.push_back(exp);
        expFixed.push_back(fixedLat);
        expCycle.push_back(strobeCycle);
    endtask

    task automatic cartRead(input addr_t a, input logic high);
        data_t v;
        v = data_t'($urandom);
        while (cpuBusy) nextCycle();
        cartData = v;
        strobeBus(1'b0, a, '0);
        expRead.push_back(v);
        expFixed.push_back(1'b1);
        expCycle.push_back(strobeCycle);
        checks++;
        if (cartSelLow !== high || cartSelHigh !== !high || cartAddr !== a[13:0]) begin
            errors++;
            $display("mismatch at %0t: cart selects %b/%b addr %h for access to %h",
                     $time, cartSelLow, cartSelHigh, cartAddr, a);
        end
        nextCycle();
        checks++;
        if (cartSelLow !== 1'b1 || cartSelHigh !== 1'b1) begin
            errors++;
            $display("cartridge select stayed low past one cycle at %0t", $time);
        end
    endtask

    // Predict one line from the model, then strobe lineStart
    task automatic fetchLine();
        addr_t base;
        base = modelScrBase + addr_t'(lineNo * LINE_BYTES);
        for (int i = 0; i < LINE_BYTES; i++) begin
            expPix.push_back(colourOf(ramModel[14'(base + addr_t'(i))]));
        end
        lineStart = 1'b1;
        nextCycle();
        lineStart = 1'b0;
        lineNo = (lineNo + 1) % FRAME_LINES;
    endtask

    task automatic waitLineEnd();
        while (expPix.size() != 0) nextCycle();
    endtask

    // Compares read returns and pixels, and bounds the run
    always @(posedge USER_CLK) begin
        cycleCount <= cycleCount + 1;
        if (!nRES_L && cpuRdValid) begin
            checks++;
            if (expRead.size() == 0) begin
                errors++;
                $display("read data returned with no read pending at %0t", $time);
            end else begin
                if (cpuRdata !== expRead[0]) begin
                    errors++;
                    $display("mismatch at %0t: read data %h, expected %h",
                             $time, cpuRdata, expRead[0]);
                end
                if (expFixed[0] && (cycleCount - expCycle[0] != REG_READ_LATENCY)) begin
                    errors++;
                    $display("fixed latency read took %0d cycles at %0t",
                             cycleCount - expCycle[0], $time);
                end
                void'(expRead.pop_front());
                void'(expFixed.pop_front());
                void'(expCycle.pop_front());
            end
        end
        if (!nRES_L && pixValid) begin
            checks++;
            if (expPix.size() == 0) begin
                errors++;
                $display("pixel output with no line pending at %0t", $time);
            end else begin
                if (pixColor !== expPix[0]) begin
                    errors++;
                    $display("mismatch at %0t: pixel %h, expected %h", $time, pixColor, expPix[0]);
                end
                void'(expPix.pop_front());
            end
        end
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("checks %0d, errors %0d", checks, errors + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h80b9));
        nRES_L     = 1'b1;
        cpuStrobe  = 1'b0;
        cpuWrite   = 1'b0;
        cpuAddr    = '0;
        cpuWdata   = '0;
        cartData   = '0;
        frameStart = 1'b0;
        lineStart  = 1'b0;
        lineNo     = 0;
        {modelColbk, modelColpf0, modelColpf1, modelColpf2} = '0;
        modelScrBase = '0;
        repeat (2) @(posedge USER_CLK);
        #1 nRES_L = 1'b0;

        // RAM write and read-back
        for (int i = 0; i < RAM_TESTS; i++) begin
            ramAddrs[i] = addr_t'($urandom % RAM_TOP);
            writeByte(ramAddrs[i], data_t'($urandom));
        end
        for (int i = 0; i < RAM_TESTS; i++) readByte(ramAddrs[i], 1'b0);

        // Chip registers with a base that wraps the screen past RAM_TOP
        writeByte(GTIA_BASE + COLBK_OFS, data_t'($urandom));
        writeByte(GTIA_BASE + COLPF0_OFS, data_t'($urandom));
        writeByte(GTIA_BASE + COLPF1_OFS, data_t'($urandom));
        writeByte(GTIA_BASE + COLPF2_OFS, data_t'($urandom));
        writeByte(ANTIC_BASE + SCRBASEL_OFS, 8'hF0);
        writeByte(ANTIC_BASE + SCRBASEH_OFS, 8'h3F);
        foreach (REG_ADDRS[i]) readByte(REG_ADDRS[i], 1'b1);

        cartRead(CART_LOW_BASE + 16'h0123, 1'b0);
        cartRead(16'h7FFF, 1'b0);
        cartRead(CART_HIGH_BASE + 16'h2A5C, 1'b1);
        cartRead(16'hBFFF, 1'b1);

        for (int i = 0; i < SCREEN_BYTES; i++) begin
            writeByte((modelScrBase + addr_t'(i)) & RAM_TOP, data_t'($urandom));
        end
        while (cpuBusy) nextCycle();

        // One frame, then wrap back to line 0
        frameStart = 1'b1;
        nextCycle();
        frameStart = 1'b0;
        lineNo = 0;
        repeat (FRAME_LINES + 1) begin
            fetchLine();
            waitLineEnd();
        end

        // CPU reads stalled behind playfield DMA
        for (int k = 0; k < 2; k++) begin
            fetchLine();
            for (int j = 0; j < 3; j++) readByte(ramAddrs[3 * k + j], 1'b0);
            waitLineEnd();
        end

        // Frame restart in the middle of the frame goes back to line 0
        frameStart = 1'b1;
        nextCycle();
        frameStart = 1'b0;
        lineNo = 0;
        fetchLine();
        waitLineEnd();

        while (cpuBusy || expRead.size() != 0) nextCycle();
        repeat (4) nextCycle(); // Catch any stray pixel or read

        errors += uut.protoCheck.assertFails; // Bound checker failures
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- consoleTop.f
verilog/consoleBus_pkg.sv
verilog/workRam.sv
verilog/busArbiter.sv
verilog/memoryMap.sv
verilog/playfieldFetch.sv
verilog/consoleTop.sv
tb/consoleTop_asserts.sv
tb/consoleTop_tb.sv
